/* rtl/riscv_pipeline_settings.svh */
`ifndef RISCV_PIPELINE_SETTINGS_SVH
`define RISCV_PIPELINE_SETTINGS_SVH

// words per cache line as a power of two
`define LINE_WORDS_LOG2 2

// width of one cache line in bits
`define LINE_BITS (32 << `LINE_WORDS_LOG2)

// number of index bits in the data cache
`define CACHE_SET_BITS 3

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

/* rtl/rv_pkg.sv */
package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS_B} alu_op_e;

    typedef enum logic [1:0] {FWD_REG, FWD_FROM_MEM, FWD_FROM_WB} fwd_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_e;

    // an all-zero payload is a bubble in every stage
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        wb_src_e     wb_src;
        logic        branch;
        logic        branch_ne;
        logic        jal;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic [31:0] pc4;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        wb_src_e     wb_src;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  rd;
        logic        reg_write;
    } mem_wb_t;

endpackage

/* rtl/dcache_if.sv */
interface dcache_if;

    // request side, held until done
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;

    // response side
    logic [31:0] rdata;
    logic        done;

    modport core (
        output read, write, addr, wdata,
        input  rdata, done
    );

    modport cache (
        input  read, write, addr, wdata,
        output rdata, done
    );

endinterface

/* rtl/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // bubble wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic            clk,
    input  rv_pkg::if_id_t  if_id,
    input  rv_pkg::mem_wb_t wb,
    output rv_pkg::id_ex_t  id_ex,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2
);

    logic [31:0] regs [32];
    logic [31:0] instr;
    logic [4:0]  rs1_f;
    logic [4:0]  rs2_f;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign instr = if_id.instr;
    assign rs1_f = instr[19:15];
    assign rs2_f = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_ff @(posedge clk) begin
        if (wb.reg_write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // x0 is zero
    // a write in this cycle is seen by the read
    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        if (wb.reg_write && wb.rd == idx) begin
            return wb.result;
        end
        return regs[idx];
    endfunction

    // source numbers stay zero when unused, so no false hazards
    always_comb begin
        id_ex = '0;
        id_ex.pc = if_id.pc;
        id_ex.rd = instr[11:7];
        id_ex.rs1_data = read_reg(rs1_f);
        id_ex.rs2_data = read_reg(rs2_f);
        case (instr[6:0])
            rv_pkg::OPC_OP: begin
                id_ex.rs1 = rs1_f;
                id_ex.rs2 = rs2_f;
                id_ex.reg_write = 1'b1;
                case (instr[14:12])
                    3'b000: begin
                        if (instr[30]) begin
                            id_ex.alu_op = rv_pkg::ALU_SUB;
                        end
                    end
                    3'b110: id_ex.alu_op = rv_pkg::ALU_OR;
                    3'b111: id_ex.alu_op = rv_pkg::ALU_AND;
                    default: id_ex.reg_write = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                id_ex.rs1 = rs1_f;
                id_ex.imm = imm_i;
                id_ex.alu_src_imm = 1'b1;
                id_ex.reg_write = (instr[14:12] == 3'b000);
            end
            rv_pkg::OPC_LUI: begin
                id_ex.imm = imm_u;
                id_ex.alu_src_imm = 1'b1;
                id_ex.alu_op = rv_pkg::ALU_PASS_B;
                id_ex.reg_write = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                id_ex.rs1 = rs1_f;
                id_ex.imm = imm_i;
                id_ex.alu_src_imm = 1'b1;
                id_ex.mem_read = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.wb_src = rv_pkg::WB_MEM;
            end
            rv_pkg::OPC_STORE: begin
                id_ex.rs1 = rs1_f;
                id_ex.rs2 = rs2_f;
                id_ex.imm = imm_s;
                id_ex.alu_src_imm = 1'b1;
                id_ex.mem_write = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                id_ex.rs1 = rs1_f;
                id_ex.rs2 = rs2_f;
                id_ex.imm = imm_b;
                id_ex.branch = 1'b1;
                id_ex.branch_ne = instr[12];
            end
            rv_pkg::OPC_JAL: begin
                id_ex.imm = imm_j;
                id_ex.jal = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.wb_src = rv_pkg::WB_PC4;
            end
            default: id_ex = '0;
        endcase
    end

    assign rs1 = id_ex.rs1;
    assign rs2 = id_ex.rs2;

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::fwd_sel_e fwd_a,
    input  rv_pkg::fwd_sel_e fwd_b,
    input  logic [31:0]      mem_result,
    input  logic [31:0]      wb_result,
    output rv_pkg::ex_mem_t  ex_mem,
    output logic             redirect,
    output logic [31:0]      target
);

    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] alu_b;

    function automatic logic [31:0] pick(input rv_pkg::fwd_sel_e sel, input logic [31:0] reg_val);
        case (sel)
            rv_pkg::FWD_FROM_MEM: return mem_result;
            rv_pkg::FWD_FROM_WB:  return wb_result;
            default:              return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a = pick(fwd_a, id_ex.rs1_data);
        rs2_val = pick(fwd_b, id_ex.rs2_data);
        alu_b = id_ex.alu_src_imm ? id_ex.imm : rs2_val;
        case (id_ex.alu_op)
            rv_pkg::ALU_SUB:    ex_mem.alu_result = op_a - alu_b;
            rv_pkg::ALU_AND:    ex_mem.alu_result = op_a & alu_b;
            rv_pkg::ALU_OR:     ex_mem.alu_result = op_a | alu_b;
            rv_pkg::ALU_PASS_B: ex_mem.alu_result = alu_b;
            default:            ex_mem.alu_result = op_a + alu_b;
        endcase
        ex_mem.store_data = rs2_val;
        ex_mem.rd = id_ex.rd;
        ex_mem.pc4 = id_ex.pc + 32'd4;
        ex_mem.mem_read = id_ex.mem_read;
        ex_mem.mem_write = id_ex.mem_write;
        ex_mem.reg_write = id_ex.reg_write;
        ex_mem.wb_src = id_ex.wb_src;
    end

    // beq when equal, bne when not
    assign redirect = id_ex.jal || (id_ex.branch && ((op_a == rs2_val) != id_ex.branch_ne));
    assign target = id_ex.pc + id_ex.imm;

endmodule

/* rtl/hazard_unit.sv */
module hazard_unit (
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::ex_mem_t  ex_mem,
    input  rv_pkg::mem_wb_t  mem_wb,
    input  logic [4:0]       rs1_id,
    input  logic [4:0]       rs2_id,
    input  logic             redirect,
    input  logic             mem_busy,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b,
    output logic             stall_if,
    output logic             stall_id,
    output logic             stall_ex,
    output logic             stall_mem,
    output logic             bubble_ex,
    output logic             bubble_wb,
    output logic             flush_id
);

    logic load_use;

    // newest producer first
    function automatic rv_pkg::fwd_sel_e source(input logic [4:0] rs);
        if (rs == 5'd0) begin
            return rv_pkg::FWD_REG;
        end
        if (ex_mem.reg_write && ex_mem.rd == rs) begin
            return rv_pkg::FWD_FROM_MEM;
        end
        if (mem_wb.reg_write && mem_wb.rd == rs) begin
            return rv_pkg::FWD_FROM_WB;
        end
        return rv_pkg::FWD_REG;
    endfunction

    always_comb begin
        fwd_a = source(id_ex.rs1);
        fwd_b = source(id_ex.rs2);
    end

    assign load_use = id_ex.mem_read && id_ex.rd != 5'd0 &&
                      (id_ex.rd == rs1_id || id_ex.rd == rs2_id);

    // pending cache access freezes IF through MEM
    assign stall_mem = mem_busy;
    assign stall_ex  = mem_busy;
    assign stall_id  = mem_busy || load_use;
    assign stall_if  = stall_id;
    assign bubble_wb = mem_busy;

    // branch in EX waits while frozen
    assign flush_id  = redirect && !mem_busy;
    assign bubble_ex = !mem_busy && (redirect || load_use);

endmodule

/* rtl/data_cache.sv */
`include "riscv_pipeline_settings.svh"

module data_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    dcache_if.cache               core,
    output logic                  data_bus_read_request,
    output logic                  data_bus_write_request,
    output logic [31:0]           data_bus_addr,
    output logic [`LINE_BITS-1:0] data_bus_write_data,
    input  logic                  data_bus_request_finish,
    input  logic [`LINE_BITS-1:0] data_bus_read_data
);

    localparam int OFFSET_BITS = `LINE_WORDS_LOG2 + 2;
    localparam int TAG_BITS    = 32 - `CACHE_SET_BITS - OFFSET_BITS;
    localparam int SETS        = 1 << `CACHE_SET_BITS;

    typedef enum logic [1:0] {IDLE, REFILL, WRITE, DONE} state_e;

    state_e state;

    logic [TAG_BITS-1:0]   tags  [SETS];
    logic [`LINE_BITS-1:0] lines [SETS];
    logic [SETS-1:0]       valid;

    logic [TAG_BITS-1:0]         tag;
    logic [`CACHE_SET_BITS-1:0]  index;
    logic [`LINE_WORDS_LOG2-1:0] word;
    logic                        hit;
    logic [`LINE_BITS-1:0]       merged;

    assign tag   = core.addr[31 -: TAG_BITS];
    assign index = core.addr[OFFSET_BITS +: `CACHE_SET_BITS];
    assign word  = core.addr[2 +: `LINE_WORDS_LOG2];
    assign hit   = valid[index] && tags[index] == tag;

    // store word dropped into the cached copy of its line
    always_comb begin
        merged = lines[index];
        merged[word*32 +: 32] = core.wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            valid <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if ((core.read || core.write) && !hit) begin
                        state <= REFILL;
                    end else if (core.write) begin
                        state <= WRITE;
                    end
                end
                REFILL: begin
                    if (data_bus_request_finish) begin
                        valid[index] <= 1'b1;
                        state <= core.write ? WRITE : DONE;
                    end
                end
                WRITE: begin
                    if (data_bus_request_finish) begin
                        state <= DONE;
                    end
                end
                DONE: state <= IDLE;
            endcase
        end
    end

    // line and tag storage
    always_ff @(posedge clk) begin
        if (state == REFILL && data_bus_request_finish) begin
            tags[index]  <= tag;
            lines[index] <= data_bus_read_data;
        end else if (state == WRITE && data_bus_request_finish) begin
            lines[index] <= merged;
        end
    end

    // requests come straight from the state, so they drop right after finish
    assign data_bus_read_request  = (state == REFILL);
    assign data_bus_write_request = (state == WRITE);
    assign data_bus_addr          = {core.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign data_bus_write_data    = merged;

    // read hit answers in the request cycle
    assign core.rdata = lines[index][word*32 +: 32];
    assign core.done  = (state == DONE) || (state == IDLE && core.read && hit);

endmodule

/* rtl/riscv_pipeline.sv */
`include "riscv_pipeline_settings.svh"

module riscv_pipeline (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           instr,
    output logic [31:0]           instr_addr,
    output logic                  data_bus_read_request,
    output logic                  data_bus_write_request,
    output logic [31:0]           data_bus_addr,
    output logic [`LINE_BITS-1:0] data_bus_write_data,
    input  logic                  data_bus_request_finish,
    input  logic [`LINE_BITS-1:0] data_bus_read_data
);

    logic [31:0] pc;
    logic [31:0] target;
    logic [31:0] mem_result;
    logic [4:0]  rs1_id;
    logic [4:0]  rs2_id;
    logic        redirect;
    logic        mem_busy;
    logic        stall_if, stall_id, stall_ex, stall_mem;
    logic        bubble_ex, bubble_wb, flush_id;

    rv_pkg::fwd_sel_e fwd_a, fwd_b;
    rv_pkg::if_id_t   if_id_d, if_id_q;
    rv_pkg::id_ex_t   id_ex_dec, id_ex_d, id_ex_q;
    rv_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
    rv_pkg::mem_wb_t  mem_wb_d, mem_wb_q;

    dcache_if dc ();

    // fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (!stall_if) begin
            pc <= redirect ? target : pc + 32'd4;
        end
    end

    assign instr_addr = pc;
    assign if_id_d = '{pc: pc, instr: instr};

    pipe_reg #(.payload_t(rv_pkg::if_id_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall_id), .bubble(flush_id),
        .d(if_id_d), .q(if_id_q)
    );

    decode_stage decode_i (
        .clk(clk), .if_id(if_id_q), .wb(mem_wb_q),
        .id_ex(id_ex_dec), .rs1(rs1_id), .rs2(rs2_id)
    );

    // while frozen, EX keeps operands it took from WB
    // WB turns into a bubble during the freeze
    always_comb begin
        id_ex_d = id_ex_dec;
        if (stall_ex) begin
            id_ex_d = id_ex_q;
            if (fwd_a == rv_pkg::FWD_FROM_WB) begin
                id_ex_d.rs1_data = mem_wb_q.result;
            end
            if (fwd_b == rv_pkg::FWD_FROM_WB) begin
                id_ex_d.rs2_data = mem_wb_q.result;
            end
        end
    end

    pipe_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(bubble_ex),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute_stage execute_i (
        .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_result(mem_result), .wb_result(mem_wb_q.result),
        .ex_mem(ex_mem_d), .redirect(redirect), .target(target)
    );

    pipe_reg #(.payload_t(rv_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall_mem), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // memory stage
    assign dc.read  = ex_mem_q.mem_read;
    assign dc.write = ex_mem_q.mem_write;
    assign dc.addr  = ex_mem_q.alu_result;
    assign dc.wdata = ex_mem_q.store_data;
    assign mem_busy = (ex_mem_q.mem_read || ex_mem_q.mem_write) && !dc.done;

    data_cache data_cache_i (
        .clk(clk), .rst_n(rst_n), .core(dc),
        .data_bus_read_request(data_bus_read_request),
        .data_bus_write_request(data_bus_write_request),
        .data_bus_addr(data_bus_addr),
        .data_bus_write_data(data_bus_write_data),
        .data_bus_request_finish(data_bus_request_finish),
        .data_bus_read_data(data_bus_read_data)
    );

    always_comb begin
        case (ex_mem_q.wb_src)
            rv_pkg::WB_MEM: mem_result = dc.rdata;
            rv_pkg::WB_PC4: mem_result = ex_mem_q.pc4;
            default:        mem_result = ex_mem_q.alu_result;
        endcase
    end

    assign mem_wb_d = '{result: mem_result, rd: ex_mem_q.rd, reg_write: ex_mem_q.reg_write};

    pipe_reg #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(bubble_wb),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    hazard_unit hazard_i (
        .id_ex(id_ex_q), .ex_mem(ex_mem_q), .mem_wb(mem_wb_q),
        .rs1_id(rs1_id), .rs2_id(rs2_id),
        .redirect(redirect), .mem_busy(mem_busy),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .stall_if(stall_if), .stall_id(stall_id), .stall_ex(stall_ex), .stall_mem(stall_mem),
        .bubble_ex(bubble_ex), .bubble_wb(bubble_wb), .flush_id(flush_id)
    );

endmodule

/* bench/main_memory_model.sv */
`include "riscv_pipeline_settings.svh"

module main_memory_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  read_request,
    input  logic                  write_request,
    input  logic [31:0]           addr,
    input  logic [`LINE_BITS-1:0] write_data,
    output logic                  finish,
    output logic [`LINE_BITS-1:0] read_data
);

    localparam int OFFSET_BITS = `LINE_WORDS_LOG2 + 2;
    localparam int LINES = 64;
    localparam int WORDS = 1 << `LINE_WORDS_LOG2;

    logic [`LINE_BITS-1:0] lines [LINES];
    logic [31:0] lfsr_state;
    logic        busy;
    int          wait_left;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // contents mix the lfsr stream with the word address
    initial begin
        logic [31:0] bits;
        lfsr_state = 32'h835b_f46f;
        finish = 1'b0;
        read_data = '0;
        busy = 1'b0;
        wait_left = 0;
        for (int i = 0; i < LINES; i++) begin
            for (int w = 0; w < WORDS; w++) begin
                take_bits(32, bits);
                lines[i][w*32 +: 32] = bits ^ 32'((i << OFFSET_BITS) | (w << 2));
            end
        end
    end

    // 0 to 3 wait cycles per request and finish high for one cycle
    always @(posedge clk) begin
        logic [31:0] bits;
        #1;
        if (!rst_n || finish) begin
            finish = 1'b0;
            busy = 1'b0;
        end else if (read_request || write_request) begin
            if (!busy) begin
                take_bits(2, bits);
                wait_left = int'(bits[1:0]);
                busy = 1'b1;
            end
            if (wait_left == 0) begin
                if (write_request) begin
                    lines[addr[OFFSET_BITS +: 6]] = write_data;
                end else begin
                    read_data = lines[addr[OFFSET_BITS +: 6]];
                end
                finish = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

endmodule

/* bench/riscv_pipeline_tb.sv */
`include "riscv_pipeline_settings.svh"

module riscv_pipeline_tb;

    localparam int OFFSET_BITS = `LINE_WORDS_LOG2 + 2;
    localparam int WORDS = 1 << `LINE_WORDS_LOG2;
    localparam int SETS = 1 << `CACHE_SET_BITS;
    localparam int TIMEOUT = 2000;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           instr;
    logic [31:0]           instr_addr;
    logic                  rd_req;
    logic                  wr_req;
    logic [31:0]           bus_addr;
    logic [`LINE_BITS-1:0] bus_wdata;
    logic                  finish;
    logic [`LINE_BITS-1:0] bus_rdata;

    logic [31:0] prog [32];
    logic [31:0] ref_mem [256];
    logic [31:0] ref_tags [SETS];
    logic [SETS-1:0] ref_valid;
    logic [31:0] halt_pc;

    // expected bus traffic in program order
    // kind 1 marks a write
    logic                  exp_kind [$];
    logic [31:0]           exp_addr [$];
    logic [`LINE_BITS-1:0] exp_line [$];

    logic        prev_rd, prev_wr, prev_finish;
    logic [31:0] prev_addr;

    riscv_pipeline riscv_pipeline_i (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instr_addr(instr_addr),
        .data_bus_read_request(rd_req), .data_bus_write_request(wr_req),
        .data_bus_addr(bus_addr), .data_bus_write_data(bus_wdata),
        .data_bus_request_finish(finish), .data_bus_read_data(bus_rdata)
    );

    main_memory_model memory_i (
        .clk(clk), .rst_n(rst_n), .read_request(rd_req), .write_request(wr_req),
        .addr(bus_addr), .write_data(bus_wdata), .finish(finish), .read_data(bus_rdata)
    );

    always #20 clk = ~clk;

    assign instr = (instr_addr[31:7] == '0) ? prog[instr_addr[6:2]] : 32'h0000_0013;

    task automatic fail_with(input string msg);
        $display("TESTS FAILED");
        $display("%s", msg);
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_program();
        for (int i = 0; i < 32; i++) begin
            prog[i] = 32'h0000_0013;
        end
        prog[0]  = i_type(12'h100, 0, 3'b000, 1, 7'b0010011);
        prog[1]  = i_type(12'd5, 0, 3'b000, 2, 7'b0010011);
        // chain through MEM and WB forwarding
        prog[2]  = i_type(12'd7, 2, 3'b000, 3, 7'b0010011);
        prog[3]  = r_type(7'h00, 2, 3, 3'b000, 4);
        prog[4]  = r_type(7'h20, 3, 4, 3'b000, 5);
        prog[5]  = s_type(12'h000, 5, 1);
        prog[6]  = s_type(12'h004, 4, 1);
        // load then direct use
        prog[7]  = i_type(12'h008, 1, 3'b010, 6, 7'b0000011);
        prog[8]  = r_type(7'h00, 4, 6, 3'b000, 7);
        prog[9]  = s_type(12'h00c, 7, 1);
        prog[10] = i_type(12'h014, 1, 3'b010, 8, 7'b0000011);
        prog[11] = i_type(12'h018, 1, 3'b010, 9, 7'b0000011);
        prog[12] = r_type(7'h00, 9, 8, 3'b110, 10);
        prog[13] = r_type(7'h00, 9, 8, 3'b111, 11);
        // same index as 0x100 so it evicts that line
        prog[14] = s_type(12'h080, 10, 1);
        prog[15] = i_type(12'h000, 1, 3'b010, 12, 7'b0000011);
        prog[16] = b_type(3'b000, 12, 5, 13'd8);
        prog[17] = s_type(12'h010, 11, 1);
        prog[18] = b_type(3'b001, 12, 5, 13'd8);
        prog[19] = s_type(12'h01c, 11, 1);
        prog[20] = j_type(13, 21'd8);
        prog[21] = s_type(12'h020, 12, 1);
        prog[22] = s_type(12'h024, 13, 1);
        prog[23] = {20'habcde, 5'd14, 7'b0110111};
        prog[24] = i_type(12'h123, 14, 3'b000, 14, 7'b0010011);
        prog[25] = s_type(12'h028, 14, 1);
        // untaken beq and taken bne
        prog[26] = b_type(3'b000, 12, 4, 13'd8);
        prog[27] = s_type(12'h02c, 4, 1);
        prog[28] = b_type(3'b001, 12, 4, 13'd8);
        prog[29] = s_type(12'h030, 12, 1);
        prog[30] = j_type(0, 21'd0);
    endtask

    // a miss in the direct-mapped tags means one line read
    task automatic touch_line(input logic [31:0] addr);
        logic [`CACHE_SET_BITS-1:0] idx;
        idx = addr[OFFSET_BITS +: `CACHE_SET_BITS];
        if (!ref_valid[idx] || ref_tags[idx] != (addr >> (OFFSET_BITS + `CACHE_SET_BITS))) begin
            ref_valid[idx] = 1'b1;
            ref_tags[idx] = addr >> (OFFSET_BITS + `CACHE_SET_BITS);
            exp_kind.push_back(1'b0);
            exp_addr.push_back({addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}});
            exp_line.push_back('0);
        end
    endtask

    task automatic run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc, ins, a, b, addr, next_pc;
        logic [`LINE_BITS-1:0] line;
        logic [2:0] f3;
        logic [4:0] rd;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        ref_valid = '0;
        pc = `RESET_PC;
        for (int steps = 0; steps < 200 && prog[pc[6:2]] != 32'h0000_006f; steps++) begin
            ins = prog[pc[6:2]];
            f3 = ins[14:12];
            rd = ins[11:7];
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            next_pc = pc + 32'd4;
            case (ins[6:0])
                7'b0110011: begin
                    if (f3 == 3'b000) begin
                        regs[rd] = ins[30] ? a - b : a + b;
                    end else if (f3 == 3'b110) begin
                        regs[rd] = a | b;
                    end else begin
                        regs[rd] = a & b;
                    end
                end
                7'b0010011: regs[rd] = a + {{20{ins[31]}}, ins[31:20]};
                7'b0110111: regs[rd] = {ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    touch_line(addr);
                    regs[rd] = ref_mem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    touch_line(addr);
                    ref_mem[addr[9:2]] = b;
                    for (int w = 0; w < WORDS; w++) begin
                        line[w*32 +: 32] = ref_mem[{addr[9:OFFSET_BITS], 2'(w)}];
                    end
                    exp_kind.push_back(1'b1);
                    exp_addr.push_back({addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}});
                    exp_line.push_back(line);
                end
                7'b1100011: begin
                    if ((a == b) != f3[0]) begin
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: begin
                    regs[rd] = pc + 32'd4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
            endcase
            regs[0] = '0;
            pc = next_pc;
        end
        halt_pc = pc;
    endtask

    // bus protocol and traffic against the reference
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(rd_req && wr_req)) else fail_with("read and write requested together");
            if (prev_finish) begin
                assert (!(prev_rd && rd_req) && !(prev_wr && wr_req))
                    else fail_with("bus request still high in the cycle after finish");
            end else if (prev_rd || prev_wr) begin
                assert (rd_req == prev_rd && wr_req == prev_wr)
                    else fail_with("bus request dropped before finish");
                assert (bus_addr == prev_addr) else fail_with($sformatf(
                    "mismatch at %0t: data_bus_addr got %h expected %h",
                    $time, bus_addr, prev_addr));
            end
            if (rd_req || wr_req) begin
                assert (exp_kind.size() > 0) else fail_with("bus request with none expected");
                assert (wr_req == exp_kind[0]) else fail_with($sformatf(
                    "mismatch at %0t: data_bus_write_request got %b expected %b",
                    $time, wr_req, exp_kind[0]));
                assert (bus_addr == exp_addr[0]) else fail_with($sformatf(
                    "mismatch at %0t: data_bus_addr got %h expected %h",
                    $time, bus_addr, exp_addr[0]));
                if (finish) begin
                    if (wr_req) begin
                        assert (bus_wdata == exp_line[0]) else fail_with($sformatf(
                            "mismatch at %0t: data_bus_write_data got %h expected %h",
                            $time, bus_wdata, exp_line[0]));
                    end
                    void'(exp_kind.pop_front());
                    void'(exp_addr.pop_front());
                    void'(exp_line.pop_front());
                end
            end
        end
        prev_rd = rd_req && rst_n;
        prev_wr = wr_req && rst_n;
        prev_finish = finish;
        prev_addr = bus_addr;
    end

    initial begin
        int cycles;
        clk = 1'b0;
        rst_n = 1'b0;
        prev_rd = 1'b0;
        prev_wr = 1'b0;
        prev_finish = 1'b0;
        prev_addr = '0;
        build_program();
        #1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = memory_i.lines[i / WORDS][(i % WORDS)*32 +: 32];
        end
        run_reference();
        repeat (3) @(posedge clk);
        assert (instr_addr == `RESET_PC) else fail_with($sformatf(
            "mismatch at %0t: instr_addr got %h expected %h", $time, instr_addr, `RESET_PC));
        assert (!rd_req && !wr_req) else fail_with("bus request raised during reset");
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (instr_addr == `RESET_PC) else fail_with($sformatf(
            "mismatch at %0t: instr_addr got %h expected %h", $time, instr_addr, `RESET_PC));
        // run until all traffic is seen and fetch sits on the final jump
        cycles = 0;
        while (cycles < TIMEOUT && !(exp_kind.size() == 0 && instr_addr == halt_pc)) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        assert (cycles < TIMEOUT) else fail_with("timed out before the program finished");
        repeat (12) @(negedge clk);
        if (exp_kind.size() == 0 && !rd_req && !wr_req) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_with("bus traffic left over after the program finished");
        end
    end

endmodule

/* riscv_pipeline.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/dcache_if.sv
rtl/pipe_reg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/data_cache.sv
rtl/riscv_pipeline.sv
bench/main_memory_model.sv
bench/riscv_pipeline_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -j 0 --top-module riscv_pipeline_tb \
    -f riscv_pipeline.f -o sim
output="$(./obj_dir/sim 2>&1 || true)"
echo "$output"
if grep -q "TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
